//--- logic/pio_isa_pkg.sv
package pio_isa_pkg;

  localparam int INSTR_W = 16;
  localparam int DELAY_W = 5;
  localparam int OP1_W   = 3;
  localparam int OP2_W   = 5;

  // Bit positions inside the instruction word
  localparam int OPCODE_LSB = 13;
  localparam int DS_LSB     = 8;
  localparam int OP1_LSB    = 5;
  localparam int OP2_LSB    = 0;

  typedef enum logic [2:0] {
    JMP       = 3'd0,
    WAIT      = 3'd1,
    IN        = 3'd2,
    OUT       = 3'd3,
    PUSH_PULL = 3'd4,
    MOV       = 3'd5,
    IRQ       = 3'd6,
    SET       = 3'd7
  } opcode_e;

  typedef enum logic [2:0] {
    COND_ALWAYS = 3'd0,
    COND_X_ZERO = 3'd1,
    COND_X_DEC  = 3'd2, // X nonzero, then X--
    COND_Y_ZERO = 3'd3,
    COND_Y_DEC  = 3'd4,
    COND_X_NE_Y = 3'd5,
    COND_PIN    = 3'd6,
    COND_OSR_NZ = 3'd7
  } jmp_cond_e;

  typedef enum logic [1:0] {
    MOV_NONE    = 2'd0,
    MOV_INVERT  = 2'd1,
    MOV_REVERSE = 2'd2
  } mov_op_e;

  // Destination and source selectors in op1/op2
  localparam logic [2:0] SET_PINS    = 3'd0;
  localparam logic [2:0] SET_X       = 3'd1;
  localparam logic [2:0] SET_Y       = 3'd2;
  localparam logic [2:0] SET_PINDIRS = 3'd4;
  localparam logic [2:0] OUT_X       = 3'd1;
  localparam logic [2:0] MOV_X       = 3'd1;
  localparam logic [2:0] MOV_Y       = 3'd2;
  localparam logic [2:0] MOV_PC      = 3'd5;
  localparam logic [1:0] WAIT_GPIO   = 2'd0;

  typedef struct packed {
    opcode_e            opcode;
    logic [OP1_W-1:0]   op1;
    logic [OP2_W-1:0]   op2;
    logic [DELAY_W-1:0] delay;
    logic [DELAY_W-1:0] side_set;
    logic               side_valid;
  } decoded_t;

endpackage

//--- logic/pio_cfg_pkg.sv
package pio_cfg_pkg;

  localparam int PIN_W      = 32;
  localparam int PIN_IDX_W  = $clog2(PIN_W);
  localparam int PC_W       = 5;
  localparam int PROG_DEPTH = 32;
  localparam int DIV_W      = 16;

  typedef struct packed {
    logic [PC_W-1:0]      wrap_bottom;
    logic [PC_W-1:0]      wrap_top;
    logic [PIN_IDX_W-1:0] set_base;
    logic [2:0]           set_count;
    logic [PIN_IDX_W-1:0] side_base;
    logic [2:0]           side_bits;
    logic                 osr_shift_right;
    logic [PIN_IDX_W-1:0] jmp_pin_index;
    logic [DIV_W-1:0]     clk_div;
  } pio_cfg_t;

  // Pin writes requested by the current instruction
  typedef struct packed {
    logic       set_pins;
    logic       set_dirs;
    logic [4:0] set_value;
    logic       side_valid;
    logic [4:0] side_value;
  } pin_req_t;

endpackage

//--- logic/pio_clock_divider.sv
`timescale 1ns/100ps

module pio_clock_divider (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  input  logic [pio_cfg_pkg::DIV_W-1:0] clk_div,
  output logic                          tick
);
  import pio_cfg_pkg::*;

  logic [DIV_W-1:0] cnt;

  // Zero count gives a tick on the first enabled clock
  assign tick = en && ((clk_div <= 1) || (cnt <= 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!en) begin
      cnt <= '0;
    end else if (tick) begin
      cnt <= clk_div; // Reload
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  tick_spacing_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (tick && (clk_div > 1)) |=> !tick
  );

endmodule

//--- logic/pio_fetch.sv
`timescale 1ns/100ps

module pio_fetch (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              active,
  input  pio_cfg_pkg::pio_cfg_t             cfg,
  input  logic                              imem_we,
  input  logic [pio_cfg_pkg::PC_W-1:0]      imem_addr,
  input  logic [pio_isa_pkg::INSTR_W-1:0]   imem_data,
  input  pio_isa_pkg::decoded_t             dec,
  input  logic                              jump,
  input  logic                              stall,
  input  logic [pio_cfg_pkg::PC_W-1:0]      jump_target,
  output logic [pio_isa_pkg::INSTR_W-1:0]   instr,
  output logic [pio_cfg_pkg::PC_W-1:0]      pc,
  output logic                              first_tick
);
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  logic [INSTR_W-1:0] imem [PROG_DEPTH];
  logic [DELAY_W-1:0] delay_cnt;
  logic [PC_W-1:0]    pc_after; // Next PC parked during delay
  logic [PC_W-1:0]    next_pc;

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  assign instr      = imem[pc];
  assign first_tick = (delay_cnt == '0);

  always_comb begin
    if (jump) begin
      next_pc = jump_target;
    end else if (pc == cfg.wrap_top) begin
      next_pc = cfg.wrap_bottom;
    end else begin
      next_pc = pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc        <= cfg.wrap_bottom;
      pc_after  <= cfg.wrap_bottom;
      delay_cnt <= '0;
    end else if (active) begin
      if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
        if (delay_cnt == 1) begin
          pc <= pc_after; // Last delay tick
        end
      end else if (!stall) begin
        if (dec.delay != '0) begin
          delay_cnt <= dec.delay;
          pc_after  <= next_pc;
        end else begin
          pc <= next_pc;
        end
      end
    end
  end

  // Jumps and MOV PC are expected to land inside the wrap window
  pc_in_wrap_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($past(active) && (cfg.wrap_bottom <= cfg.wrap_top))
      |-> ((pc >= cfg.wrap_bottom) && (pc <= cfg.wrap_top))
  );

endmodule

//--- logic/pio_decode.sv
`timescale 1ns/100ps

module pio_decode (
  input  logic [pio_isa_pkg::INSTR_W-1:0] instr,
  input  logic [2:0]                      side_bits,
  output pio_isa_pkg::decoded_t           dec
);
  import pio_isa_pkg::*;

  logic [DELAY_W-1:0] ds_field;
  logic [2:0]         sb;
  logic [2:0]         delay_w;
  logic [DELAY_W-1:0] delay_mask;

  assign ds_field = instr[DS_LSB +: DELAY_W];

  // More than five side-set bits cannot fit the field
  assign sb = (side_bits > 3'(DELAY_W)) ? 3'(DELAY_W) : side_bits;

  assign delay_w    = 3'(DELAY_W) - sb;
  assign delay_mask = {DELAY_W{1'b1}} >> sb;

  always_comb begin
    dec.opcode     = opcode_e'(instr[OPCODE_LSB +: 3]);
    dec.op1        = instr[OP1_LSB +: OP1_W];
    dec.op2        = instr[OP2_LSB +: OP2_W];
    dec.delay      = ds_field & delay_mask;
    dec.side_set   = ds_field >> delay_w; // Upper bits, LSB aligned
    dec.side_valid = (sb != '0);
  end

endmodule

//--- logic/pio_execute.sv
`timescale 1ns/100ps

module pio_execute (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           active,
  input  pio_cfg_pkg::pio_cfg_t          cfg,
  input  pio_isa_pkg::decoded_t          dec,
  input  logic                           first_tick,
  input  logic [pio_cfg_pkg::PIN_W-1:0]  gpio_in,
  input  logic [pio_cfg_pkg::PIN_W-1:0]  tx_data,
  input  logic                           tx_empty,
  output logic                           jump,
  output logic                           stall,
  output logic [pio_cfg_pkg::PC_W-1:0]   jump_target,
  output pio_cfg_pkg::pin_req_t          pin_req,
  output logic                           pull
);
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  logic [PIN_W-1:0] x;
  logic [PIN_W-1:0] y;
  logic [PIN_W-1:0] osr;
  logic [PIN_W-1:0] x_nxt;
  logic [PIN_W-1:0] y_nxt;
  logic [PIN_W-1:0] osr_nxt;
  logic [PIN_W-1:0] mov_src;
  logic [PIN_W-1:0] mov_val;
  logic [5:0]       out_cnt;
  logic             pull_req;
  logic             set_pins;
  logic             set_dirs;

  function automatic logic [PIN_W-1:0] mov_apply(input logic [PIN_W-1:0] value,
                                                 input mov_op_e op);
    case (op)
      MOV_INVERT:  return ~value;
      MOV_REVERSE: return {<<{value}};
      default:     return value;
    endcase
  endfunction

  assign out_cnt = (dec.op2 == '0) ? 6'd32 : {1'b0, dec.op2}; // Zero means 32
  assign mov_src = (dec.op2[2:0] == MOV_X) ? x : (dec.op2[2:0] == MOV_Y) ? y : '0;
  assign mov_val = mov_apply(mov_src, mov_op_e'(dec.op2[4:3]));

  always_comb begin
    jump        = 1'b0;
    jump_target = dec.op2;
    stall       = 1'b0;
    x_nxt       = x;
    y_nxt       = y;
    osr_nxt     = osr;
    pull_req    = 1'b0;
    set_pins    = 1'b0;
    set_dirs    = 1'b0;
    case (dec.opcode)
      JMP: begin
        case (jmp_cond_e'(dec.op1))
          COND_ALWAYS: jump = 1'b1;
          COND_X_ZERO: jump = (x == '0);
          COND_X_DEC: begin
            jump  = (x != '0);
            x_nxt = x - 1'b1;
          end
          COND_Y_ZERO: jump = (y == '0);
          COND_Y_DEC: begin
            jump  = (y != '0);
            y_nxt = y - 1'b1;
          end
          COND_X_NE_Y: jump = (x != y);
          COND_PIN:    jump = gpio_in[cfg.jmp_pin_index];
          default:     jump = (osr != '0);
        endcase
      end
      WAIT: begin
        if (dec.op1[1:0] == WAIT_GPIO) begin
          stall = (gpio_in[dec.op2] != dec.op1[2]); // op1[2] is polarity
        end
      end
      PUSH_PULL: begin
        if (dec.op1[2]) begin
          if (!tx_empty) begin
            pull_req = 1'b1;
            osr_nxt  = tx_data;
          end else if (dec.op1[0]) begin
            stall = 1'b1; // Blocking
          end else begin
            osr_nxt = x;
          end
        end
      end
      OUT: begin
        if (dec.op1 == OUT_X) begin
          if (cfg.osr_shift_right) begin
            x_nxt   = (osr << (6'd32 - out_cnt)) >> (6'd32 - out_cnt);
            osr_nxt = osr >> out_cnt;
          end else begin
            x_nxt   = osr >> (6'd32 - out_cnt);
            osr_nxt = osr << out_cnt;
          end
        end
      end
      MOV: begin
        case (dec.op1)
          MOV_X: x_nxt = mov_val;
          MOV_Y: y_nxt = mov_val;
          MOV_PC: begin
            jump        = 1'b1;
            jump_target = mov_val[PC_W-1:0];
          end
          default: ;
        endcase
      end
      SET: begin
        case (dec.op1)
          SET_PINS:    set_pins = 1'b1;
          SET_X:       x_nxt = {{(PIN_W-OP2_W){1'b0}}, dec.op2};
          SET_Y:       y_nxt = {{(PIN_W-OP2_W){1'b0}}, dec.op2};
          SET_PINDIRS: set_dirs = 1'b1;
          default: ;
        endcase
      end
      default: ; // IN, IRQ and the PUSH half
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x   <= '0;
      y   <= '0;
      osr <= '0;
    end else if (active && first_tick) begin
      x   <= x_nxt;
      y   <= y_nxt;
      osr <= osr_nxt;
    end
  end

  assign pull = active && first_tick && pull_req;

  always_comb begin
    pin_req.set_pins   = set_pins && first_tick;
    pin_req.set_dirs   = set_dirs && first_tick;
    pin_req.set_value  = dec.op2;
    pin_req.side_valid = dec.side_valid && first_tick;
    pin_req.side_value = dec.side_set;
  end

  // A pop needs a word waiting in the FIFO
  pull_not_empty_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    pull |-> !tx_empty
  );

endmodule

//--- logic/pio_pin_unit.sv
`timescale 1ns/100ps

module pio_pin_unit (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          active,
  input  pio_cfg_pkg::pio_cfg_t         cfg,
  input  pio_cfg_pkg::pin_req_t         pin_req,
  output logic [pio_cfg_pkg::PIN_W-1:0] pins,
  output logic [pio_cfg_pkg::PIN_W-1:0] pin_dirs
);
  import pio_cfg_pkg::*;

  logic [PIN_W-1:0] side_mask;
  logic [PIN_W-1:0] side_val;
  logic [PIN_W-1:0] set_mask;
  logic [PIN_W-1:0] set_val;
  logic [PIN_W-1:0] pins_nxt;
  logic [PIN_W-1:0] dirs_nxt;

  function automatic logic [PIN_W-1:0] rotl(input logic [PIN_W-1:0] value,
                                            input logic [PIN_IDX_W-1:0] base);
    return (value << base) | (value >> (PIN_W - base));
  endfunction

  function automatic logic [PIN_W-1:0] low_mask(input logic [2:0] count);
    return ((32'd1 << count) - 1) & 32'h1f; // At most five pins
  endfunction

  assign side_mask = rotl(low_mask(cfg.side_bits), cfg.side_base);
  assign side_val  = rotl({27'b0, pin_req.side_value}, cfg.side_base) & side_mask;
  assign set_mask  = rotl(low_mask(cfg.set_count), cfg.set_base);
  assign set_val   = rotl({27'b0, pin_req.set_value}, cfg.set_base) & set_mask;

  always_comb begin
    pins_nxt = pins;
    dirs_nxt = pin_dirs;
    if (pin_req.side_valid) begin
      pins_nxt = (pins_nxt & ~side_mask) | side_val;
    end
    if (pin_req.set_pins) begin
      pins_nxt = (pins_nxt & ~set_mask) | set_val; // SET wins over side-set
    end
    if (pin_req.set_dirs) begin
      dirs_nxt = (dirs_nxt & ~set_mask) | set_val;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pins     <= '0;
      pin_dirs <= '0;
    end else if (active) begin
      pins     <= pins_nxt;
      pin_dirs <= dirs_nxt;
    end
  end

endmodule

//--- logic/pio_sm_top.sv
`timescale 1ns/100ps

module pio_sm_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            en,
  input  pio_cfg_pkg::pio_cfg_t           cfg,
  input  logic                            imem_we,
  input  logic [pio_cfg_pkg::PC_W-1:0]    imem_addr,
  input  logic [pio_isa_pkg::INSTR_W-1:0] imem_data,
  input  logic [pio_cfg_pkg::PIN_W-1:0]   gpio_in,
  input  logic [pio_cfg_pkg::PIN_W-1:0]   tx_data,
  input  logic                            tx_empty,
  output logic [pio_cfg_pkg::PC_W-1:0]    pc,
  output logic                            pull,
  output logic [pio_cfg_pkg::PIN_W-1:0]   pins,
  output logic [pio_cfg_pkg::PIN_W-1:0]   pin_dirs
);
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  logic               tick;
  logic               active;
  logic [INSTR_W-1:0] instr;
  decoded_t           dec;
  logic               jump;
  logic               stall;
  logic [PC_W-1:0]    jump_target;
  logic               first_tick;
  pin_req_t           pin_req;

  assign active = en & tick;

  pio_clock_divider u_divider (
    .clk(clk), .rst_n(rst_n), .en(en), .clk_div(cfg.clk_div), .tick(tick)
  );

  pio_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .active(active), .cfg(cfg),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .dec(dec), .jump(jump), .stall(stall), .jump_target(jump_target),
    .instr(instr), .pc(pc), .first_tick(first_tick)
  );

  pio_decode u_decode (
    .instr(instr), .side_bits(cfg.side_bits), .dec(dec)
  );

  pio_execute u_execute (
    .clk(clk), .rst_n(rst_n), .active(active), .cfg(cfg), .dec(dec),
    .first_tick(first_tick), .gpio_in(gpio_in), .tx_data(tx_data),
    .tx_empty(tx_empty), .jump(jump), .stall(stall),
    .jump_target(jump_target), .pin_req(pin_req), .pull(pull)
  );

  pio_pin_unit u_pin_unit (
    .clk(clk), .rst_n(rst_n), .active(active), .cfg(cfg),
    .pin_req(pin_req), .pins(pins), .pin_dirs(pin_dirs)
  );

endmodule

//--- include/pio_sm_vectors.svh
`ifndef PIO_SM_VECTORS_SVH
`define PIO_SM_VECTORS_SVH

// One row per test with program, cfg, ticks, gpio step, tx words, expected pins,
// dirs, pc and pulls, pin 0 rising edges and change spacing, and a mid-run pc probe
localparam int NUM_TESTS = 7;

logic [15:0] prog_tab [NUM_TESTS][32];
pio_cfg_t    cfg_tab  [NUM_TESTS];
int          run_ticks [NUM_TESTS];
int          gpio_at   [NUM_TESTS];
logic [31:0] gpio_val  [NUM_TESTS];
int          tx_start  [NUM_TESTS];
int          tx_count  [NUM_TESTS];
logic [31:0] exp_pins  [NUM_TESTS];
logic [31:0] exp_dirs  [NUM_TESTS];
logic [4:0]  exp_pc    [NUM_TESTS];
int          exp_pulls [NUM_TESTS];
int          exp_edges [NUM_TESTS]; // -1 skips
int          exp_gap   [NUM_TESTS]; // 0 skips
int          mid_clk   [NUM_TESTS]; // -1 skips
logic [4:0]  mid_pc    [NUM_TESTS];

task automatic set_entry(input int k, input pio_cfg_t c, input int ticks, input int gat,
                         input logic [31:0] gval, input int tst, input int tcnt,
                         input logic [31:0] p, input logic [31:0] d, input logic [4:0] pcv,
                         input int pulls, input int edges, input int gap, input int mclk,
                         input logic [4:0] mpc);
  cfg_tab[k]   = c;
  run_ticks[k] = ticks;
  gpio_at[k]   = gat;
  gpio_val[k]  = gval;
  tx_start[k]  = tst;
  tx_count[k]  = tcnt;
  exp_pins[k]  = p;
  exp_dirs[k]  = d;
  exp_pc[k]    = pcv;
  exp_pulls[k] = pulls;
  exp_edges[k] = edges;
  exp_gap[k]   = gap;
  mid_clk[k]   = mclk;
  mid_pc[k]    = mpc;
endtask

task automatic fill_table();
  for (int k = 0; k < NUM_TESTS; k++) begin
    for (int a = 0; a < 32; a++) begin
      prog_tab[k][a] = instr_word(JMP, 0, 3'd0, 5'(a)); // Jump to self
    end
  end
  // SET with wrap past pin 31
  prog_tab[0][0] = instr_word(SET, 0, SET_PINDIRS, 5'd11);
  prog_tab[0][1] = instr_word(SET, 0, SET_PINS, 5'd6);
  set_entry(0, make_cfg(0, 31, 30, 4, 0, 0, 0, 1), 5, -1, 0, 0, 0,
            32'h8000_0001, 32'hc000_0002, 5'd2, 0, -1, 0, -1, 0);
  prog_tab[1][0] = instr_word(SET, 0, SET_PINDIRS, 5'd31);
  prog_tab[1][1] = instr_word(SET, 0, SET_PINS, 5'd5);
  set_entry(1, make_cfg(0, 31, 3, 3, 0, 0, 0, 1), 5, -1, 0, 0, 0,
            32'h0000_0028, 32'h0000_0038, 5'd2, 0, -1, 0, -1, 0);
  // X loop with side-set toggle on pin 0
  prog_tab[2][0] = instr_word(SET, 0, SET_X, 5'd3);
  prog_tab[2][1] = instr_word(SET, 16, SET_Y, 5'd0);
  prog_tab[2][2] = instr_word(JMP, 0, 3'd2, 5'd1);
  set_entry(2, make_cfg(0, 31, 0, 0, 0, 1, 0, 1), 12, -1, 0, 0, 0,
            0, 0, 5'd3, 0, 4, 0, -1, 0);
  // Toggle with delay 2 at divide by 3
  prog_tab[3][0] = instr_word(SET, 2, SET_PINS, 5'd1);
  prog_tab[3][1] = instr_word(SET, 2, SET_PINS, 5'd0);
  set_entry(3, make_cfg(0, 1, 0, 1, 0, 0, 0, 3), 12, -1, 0, 0, 0,
            0, 0, 5'd0, 0, 2, 9, -1, 0);
  // Blocking pull; pins and pc predicted from the tx word later
  prog_tab[4][0]  = instr_word(PUSH_PULL, 0, 3'b101, 5'd0);
  prog_tab[4][1]  = instr_word(OUT, 0, OUT_X, 5'd5);
  prog_tab[4][2]  = instr_word(MOV, 0, MOV_Y, 5'b10_001);
  prog_tab[4][3]  = instr_word(JMP, 0, 3'd5, 5'd6);
  prog_tab[4][4]  = instr_word(SET, 0, SET_PINS, 5'd1);
  prog_tab[4][6]  = instr_word(SET, 0, SET_PINS, 5'd2);
  prog_tab[4][7]  = instr_word(JMP, 0, 3'd7, 5'd9);
  prog_tab[4][9]  = instr_word(SET, 0, SET_PINS, 5'd3);
  set_entry(4, make_cfg(0, 31, 0, 2, 0, 0, 1, 1), 14, -1, 0, 4, 1,
            0, 0, 5'd0, 1, -1, 0, 3, 5'd0);
  // Wait for gpio 7 high
  prog_tab[5][0] = instr_word(WAIT, 0, 3'b100, 5'd7);
  prog_tab[5][1] = instr_word(SET, 0, SET_PINS, 5'd21);
  set_entry(5, make_cfg(0, 31, 8, 5, 0, 0, 0, 1), 10, 6, 32'h80, 0, 0,
            32'h0000_1500, 0, 5'd2, 0, -1, 0, 4, 5'd0);
  // Wrap window 2..7, MOV PC from inverted X skips address 6
  prog_tab[6][0] = instr_word(SET, 0, SET_PINS, 5'd7);
  prog_tab[6][2] = instr_word(SET, 0, SET_X, 5'd24);
  prog_tab[6][3] = instr_word(SET, 0, SET_Y, 5'd1);
  prog_tab[6][4] = instr_word(JMP, 0, 3'd4, 5'd4);
  prog_tab[6][5] = instr_word(MOV, 0, MOV_PC, 5'b01_001);
  prog_tab[6][6] = instr_word(SET, 0, SET_PINDIRS, 5'd7);
  prog_tab[6][7] = instr_word(SET, 0, SET_PINS, 5'd2);
  set_entry(6, make_cfg(2, 7, 0, 3, 0, 0, 0, 1), 12, -1, 0, 0, 0,
            32'h2, 0, 5'd2, 0, -1, 0, 5, 5'd7);
endtask

`endif

//--- testbench/pio_sm_tb.sv
`timescale 1ns/100ps

module pio_sm_tb;
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        en;
  pio_cfg_t    cfg;
  logic        imem_we;
  logic [4:0]  imem_addr;
  logic [15:0] imem_data;
  logic [31:0] gpio_in;
  logic [31:0] tx_data;
  logic        tx_empty;
  logic [4:0]  pc;
  logic        pull;
  logic [31:0] pins;
  logic [31:0] pin_dirs;
  int          errors;
  int          checks;
  int          seed;
  logic [31:0] tx_word [7];

  function automatic logic [15:0] instr_word(input opcode_e op, input int ds,
                                             input logic [2:0] op1, input logic [4:0] op2);
    return {op, 5'(ds), op1, op2};
  endfunction

  function automatic pio_cfg_t make_cfg(input int wb, input int wt, input int sbase,
                                        input int scnt, input int sdbase, input int sdbits,
                                        input int shr, input int div);
    pio_cfg_t c;
    c.wrap_bottom     = 5'(wb);
    c.wrap_top        = 5'(wt);
    c.set_base        = 5'(sbase);
    c.set_count       = 3'(scnt);
    c.side_base       = 5'(sdbase);
    c.side_bits       = 3'(sdbits);
    c.osr_shift_right = 1'(shr);
    c.jmp_pin_index   = '0;
    c.clk_div         = 16'(div);
    return c;
  endfunction

  `include "pio_sm_vectors.svh"

  pio_sm_top u_pio_sm_top (
    .clk(clk), .rst_n(rst_n), .en(en), .cfg(cfg), .imem_we(imem_we),
    .imem_addr(imem_addr), .imem_data(imem_data), .gpio_in(gpio_in), .tx_data(tx_data),
    .tx_empty(tx_empty), .pc(pc), .pull(pull), .pins(pins), .pin_dirs(pin_dirs)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // OUT 5 right, reverse into Y, then X!=Y and OSR nonzero pick the pattern
  task automatic predict_pull_test(input int k, input logic [31:0] word);
    logic [31:0] xv;
    logic [31:0] yv;
    logic [31:0] osr_left;
    xv = word & 32'h1f;
    osr_left = word >> 5;
    for (int i = 0; i < 32; i++) begin
      yv[31-i] = xv[i];
    end
    if (xv == yv) begin
      exp_pins[k] = 32'd1;
      exp_pc[k]   = 5'd5;
    end else if (osr_left != 0) begin
      exp_pins[k] = 32'd3;
      exp_pc[k]   = 5'd10;
    end else begin
      exp_pins[k] = 32'd2;
      exp_pc[k]   = 5'd8;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic run_entry(input int k);
    int run_clks;
    int pulls;
    int edges;
    int last_change;
    logic prev_pin;
    run_clks = run_ticks[k] * ((cfg_tab[k].clk_div > 1) ? int'(cfg_tab[k].clk_div) : 1);
    for (int a = 0; a < 32; a++) begin
      @(negedge clk);
      imem_we   = 1'b1;
      imem_addr = 5'(a);
      imem_data = prog_tab[k][a];
    end
    @(negedge clk);
    imem_we = 1'b0;
    cfg     = cfg_tab[k];
    rst_n   = 1'b0;
    repeat (5) @(negedge clk);
    rst_n       = 1'b1;
    pulls       = 0;
    edges       = 0;
    last_change = -1;
    prev_pin    = pins[0];
    for (int c = 0; c <= run_clks; c++) begin
      @(negedge clk);
      if (pins[0] !== prev_pin) begin
        if (prev_pin == 1'b0) edges++;
        if (last_change >= 0 && exp_gap[k] > 0) check_value("pin gap", c - last_change, exp_gap[k]);
        last_change = c;
        prev_pin    = pins[0];
      end
      if (c == mid_clk[k]) check_value("pc while held", pc, mid_pc[k]);
      if (c == run_clks) break;
      en       = 1'b1;
      gpio_in  = (gpio_at[k] >= 0 && c >= gpio_at[k]) ? gpio_val[k] : '0;
      tx_empty = !(tx_count[k] > 0 && c >= tx_start[k] && pulls < tx_count[k]);
      tx_data  = tx_word[k];
      #1;
      if (pull) pulls++;
    end
    en = 1'b0;
    check_value("pins", pins, exp_pins[k]);
    check_value("pin_dirs", pin_dirs, exp_dirs[k]);
    check_value("pc", pc, exp_pc[k]);
    check_value("pull count", pulls, exp_pulls[k]);
    if (exp_edges[k] >= 0) check_value("rising edges", edges, exp_edges[k]);
  endtask

  initial begin
    int limit;
    #1;
    limit = 1000;
    for (int k = 0; k < NUM_TESTS; k++) begin
      limit += run_ticks[k] * ((cfg_tab[k].clk_div > 1) ? int'(cfg_tab[k].clk_div) : 1);
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the test run hung and did not finish");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    en        = 1'b0;
    cfg       = '0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    gpio_in   = '0;
    tx_data   = '0;
    tx_empty  = 1'b1;
    errors    = 0;
    checks    = 0;
    seed      = 32'hdeb0;
    fill_table();
    for (int k = 0; k < NUM_TESTS; k++) begin
      tx_word[k] = $random(seed);
    end
    predict_pull_test(4, tx_word[4]);
    for (int k = 0; k < NUM_TESTS; k++) begin
      run_entry(k);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
logic/pio_isa_pkg.sv
logic/pio_cfg_pkg.sv
logic/pio_clock_divider.sv
logic/pio_fetch.sv
logic/pio_decode.sv
logic/pio_execute.sv
logic/pio_pin_unit.sv
logic/pio_sm_top.sv
testbench/pio_sm_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module pio_sm_tb -o pio_sm_sim \
  && ./obj_dir/pio_sm_sim | tee /dev/stderr | grep -q "^Simulation passed$" \
  && echo "Run finished: PASS" \
  || { echo "Run finished: FAIL"; exit 1; }
